// ==== include/mbx_defs.svh ====
`ifndef MBX_DEFS_SVH
`define MBX_DEFS_SVH

// width of a full bus address on both ports
`define MBX_ADDR_WIDTH 8

// width of one mailbox word
`define MBX_DATA_WIDTH 16

// low address bits used as slot index
// four slots with the default of 2
`define MBX_IDX_BITS 2

// store write attempts before the write port gives up
// counts refusals, not bus cycles
`define MBX_RETRY_LIMIT 4

`endif

// ==== rtl/mbx_pkg.sv ====
`include "mbx_defs.svh"

package mbx_pkg;

  // full bus address
  typedef logic [`MBX_ADDR_WIDTH-1:0] addr_t;

  // one stored word
  typedef logic [`MBX_DATA_WIDTH-1:0] data_t;

  // slot index, taken from the low address bits
  typedef logic [`MBX_IDX_BITS-1:0] idx_t;

  // high address bits kept per slot
  typedef logic [`MBX_ADDR_WIDTH-`MBX_IDX_BITS-1:0] tag_t;

  // outcome of one bus cycle
  // ack for a taken write or a hit read
  // err for a refused write or a missed read
  typedef enum logic {
    RESP_ACK = 1'b0,
    RESP_ERR = 1'b1
  } mbx_resp_e;

endpackage

// ==== rtl/mbx_write_port.sv ====
`timescale 1ns/10ps
`include "mbx_defs.svh"

module mbx_write_port (
  input  logic               clk,
  input  logic               reset_n,
  // wishbone classic write slave
  input  logic               wr_cyc_i,
  input  logic               wr_stb_i,
  input  mbx_pkg::addr_t     wr_adr_i,
  input  mbx_pkg::data_t     wr_dat_i,
  output logic               wr_ack_o,
  output logic               wr_err_o,
  // write request toward the store
  output logic               st_wreq_o,
  output mbx_pkg::addr_t     st_waddr_o,
  output mbx_pkg::data_t     st_wdata_o,
  input  logic               st_wdone_i,
  input  logic               st_wrefuse_i
);

  // wide enough to hold the retry limit itself
  localparam int CNT_W = $clog2(`MBX_RETRY_LIMIT + 1);

  // fsm encoding
  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_ISSUE   = 2'd1;
  localparam logic [1:0] S_WAIT    = 2'd2;
  localparam logic [1:0] S_RESPOND = 2'd3;

  logic [1:0]         state_q;
  logic               stb_q;
  logic               start;
  logic               last_try;
  logic [CNT_W-1:0]   refuse_cnt_q;
  mbx_pkg::mbx_resp_e resp_q;
  mbx_pkg::addr_t     addr_q;
  mbx_pkg::data_t     data_q;

  // new bus cycle only on a rising strobe
  // a strobe still high after the response does not restart
  assign start = wr_cyc_i && wr_stb_i && !stb_q && (state_q == S_IDLE);

  // this refusal is the last one allowed
  assign last_try = (refuse_cnt_q == CNT_W'(`MBX_RETRY_LIMIT - 1));

  // strobe history for edge detection
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stb_q <= 1'b0;
    end else begin
      stb_q <= wr_cyc_i && wr_stb_i;
    end
  end

  // idle, issue, wait, respond
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q      <= S_IDLE;
      refuse_cnt_q <= '0;
      resp_q       <= mbx_pkg::RESP_ACK;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start) begin
            state_q      <= S_ISSUE;
            refuse_cnt_q <= '0;
          end
        end
        // request is out for exactly this cycle
        S_ISSUE: begin
          state_q <= S_WAIT;
        end
        // store answers one cycle after the request
        S_WAIT: begin
          if (st_wdone_i) begin
            resp_q  <= mbx_pkg::RESP_ACK;
            state_q <= S_RESPOND;
          end else if (st_wrefuse_i) begin
            if (last_try) begin
              resp_q  <= mbx_pkg::RESP_ERR;
              state_q <= S_RESPOND;
            end else begin
              // slot busy or read had priority, try again
              refuse_cnt_q <= refuse_cnt_q + 1'b1;
              state_q      <= S_ISSUE;
            end
          end
        end
        // single response pulse
        S_RESPOND: begin
          state_q <= S_IDLE;
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // address and word held for all retries
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= wr_adr_i;
      data_q <= wr_dat_i;
    end
  end

  assign st_wreq_o  = (state_q == S_ISSUE);
  assign st_waddr_o = addr_q;
  assign st_wdata_o = data_q;

  // outcome decides which pulse, never both
  assign wr_ack_o = (state_q == S_RESPOND) && (resp_q == mbx_pkg::RESP_ACK);
  assign wr_err_o = (state_q == S_RESPOND) && (resp_q == mbx_pkg::RESP_ERR);

endmodule

// ==== rtl/mbx_store.sv ====
`timescale 1ns/10ps
`include "mbx_defs.svh"

module mbx_store (
  input  logic           clk,
  input  logic           reset_n,
  // write side
  input  logic           st_wreq_i,
  input  mbx_pkg::addr_t st_waddr_i,
  input  mbx_pkg::data_t st_wdata_i,
  output logic           st_wdone_o,
  output logic           st_wrefuse_o,
  // read side
  input  logic           st_rreq_i,
  input  mbx_pkg::addr_t st_raddr_i,
  output logic           st_rdone_o,
  output logic           st_rhit_o,
  output mbx_pkg::data_t st_rdata_o
);

  // one slot per index value
  localparam int NUM_SLOTS = 1 << `MBX_IDX_BITS;

  // slot payload
  mbx_pkg::data_t       mem_data [NUM_SLOTS];
  mbx_pkg::tag_t        mem_tag  [NUM_SLOTS];
  // slot control flags
  logic [NUM_SLOTS-1:0] valid_q;
  logic [NUM_SLOTS-1:0] read_q;

  mbx_pkg::idx_t        ridx;
  mbx_pkg::tag_t        rtag;
  mbx_pkg::idx_t        widx;
  mbx_pkg::tag_t        wtag;
  logic                 rhit;
  logic                 wtake;

  // split addresses into index and tag
  assign ridx = st_raddr_i[`MBX_IDX_BITS-1:0];
  assign rtag = st_raddr_i[`MBX_ADDR_WIDTH-1:`MBX_IDX_BITS];
  assign widx = st_waddr_i[`MBX_IDX_BITS-1:0];
  assign wtag = st_waddr_i[`MBX_ADDR_WIDTH-1:`MBX_IDX_BITS];

  // hit needs a valid slot and the same tag
  assign rhit = valid_q[ridx] && (mem_tag[ridx] == rtag);

  // write only over a word that was already read
  // a read in the same cycle wins
  assign wtake = st_wreq_i && read_q[widx] && !st_rreq_i;

  // slots start empty and writable
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
      read_q  <= '1;
    end else begin
      // a miss leaves the read flag alone
      if (st_rreq_i && rhit) begin
        read_q[ridx] <= 1'b1;
      end
      // new word must be read before the next overwrite
      if (wtake) begin
        valid_q[widx] <= 1'b1;
        read_q[widx]  <= 1'b0;
      end
    end
  end

  // word and tag storage
  always_ff @(posedge clk) begin
    if (wtake) begin
      mem_data[widx] <= st_wdata_i;
      mem_tag[widx]  <= wtag;
    end
  end

  // result pulses, one cycle after each request
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      st_rdone_o   <= 1'b0;
      st_rhit_o    <= 1'b0;
      st_wdone_o   <= 1'b0;
      st_wrefuse_o <= 1'b0;
    end else begin
      // reads always complete
      st_rdone_o   <= st_rreq_i;
      st_rhit_o    <= st_rreq_i && rhit;
      // exactly one of these per write request
      st_wdone_o   <= wtake;
      st_wrefuse_o <= st_wreq_i && !wtake;
    end
  end

  // read data, only meaningful with a hit
  always_ff @(posedge clk) begin
    if (st_rreq_i) begin
      st_rdata_o <= mem_data[ridx];
    end
  end

endmodule

// ==== rtl/mbx_read_port.sv ====
`timescale 1ns/10ps
`include "mbx_defs.svh"

module mbx_read_port (
  input  logic           clk,
  input  logic           reset_n,
  // wishbone classic read slave
  input  logic           rd_cyc_i,
  input  logic           rd_stb_i,
  input  mbx_pkg::addr_t rd_adr_i,
  output mbx_pkg::data_t rd_dat_o,
  output logic           rd_ack_o,
  output logic           rd_err_o,
  // read request toward the store
  output logic           st_rreq_o,
  output mbx_pkg::addr_t st_raddr_o,
  input  logic           st_rdone_i,
  input  logic           st_rhit_i,
  input  mbx_pkg::data_t st_rdata_i
);

  logic               stb_q;
  logic               pending_q;
  logic               start;
  logic               rreq_q;
  logic               rsp_vld_q;
  mbx_pkg::mbx_resp_e resp_q;
  mbx_pkg::addr_t     addr_q;
  mbx_pkg::data_t     dat_q;

  // one store read per rising strobe
  assign start = rd_cyc_i && rd_stb_i && !stb_q && !pending_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stb_q     <= 1'b0;
      pending_q <= 1'b0;
      rreq_q    <= 1'b0;
      rsp_vld_q <= 1'b0;
      resp_q    <= mbx_pkg::RESP_ACK;
    end else begin
      stb_q     <= rd_cyc_i && rd_stb_i;
      // issue cycle
      rreq_q    <= start;
      // response lasts a single cycle
      rsp_vld_q <= st_rdone_i;
      if (start) begin
        pending_q <= 1'b1;
      end else if (st_rdone_i) begin
        pending_q <= 1'b0;
      end
      // outcome from the store result
      if (st_rdone_i) begin
        resp_q <= st_rhit_i ? mbx_pkg::RESP_ACK : mbx_pkg::RESP_ERR;
      end
    end
  end

  // address held for the store cycle
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= rd_adr_i;
    end
  end

  // bus data changes only on a hit
  always_ff @(posedge clk) begin
    if (st_rdone_i && st_rhit_i) begin
      dat_q <= st_rdata_i;
    end
  end

  assign st_rreq_o  = rreq_q;
  assign st_raddr_o = addr_q;
  assign rd_dat_o   = dat_q;

  // matching pulse for the held outcome
  assign rd_ack_o = rsp_vld_q && (resp_q == mbx_pkg::RESP_ACK);
  assign rd_err_o = rsp_vld_q && (resp_q == mbx_pkg::RESP_ERR);

endmodule

// ==== rtl/mbx_top.sv ====
`timescale 1ns/10ps
`include "mbx_defs.svh"

module mbx_top (
  input  logic           clk,
  input  logic           reset_n,
  // write bus
  input  logic           wr_cyc_i,
  input  logic           wr_stb_i,
  input  mbx_pkg::addr_t wr_adr_i,
  input  mbx_pkg::data_t wr_dat_i,
  output logic           wr_ack_o,
  output logic           wr_err_o,
  // read bus
  input  logic           rd_cyc_i,
  input  logic           rd_stb_i,
  input  mbx_pkg::addr_t rd_adr_i,
  output mbx_pkg::data_t rd_dat_o,
  output logic           rd_ack_o,
  output logic           rd_err_o
);

  // write port to store
  logic           st_wreq;
  mbx_pkg::addr_t st_waddr;
  mbx_pkg::data_t st_wdata;
  logic           st_wdone;
  logic           st_wrefuse;

  // read port to store
  logic           st_rreq;
  mbx_pkg::addr_t st_raddr;
  logic           st_rdone;
  logic           st_rhit;
  mbx_pkg::data_t st_rdata;

  // producer side
  mbx_write_port u_write_port (
    .clk          (clk),
    .reset_n      (reset_n),
    .wr_cyc_i     (wr_cyc_i),
    .wr_stb_i     (wr_stb_i),
    .wr_adr_i     (wr_adr_i),
    .wr_dat_i     (wr_dat_i),
    .wr_ack_o     (wr_ack_o),
    .wr_err_o     (wr_err_o),
    .st_wreq_o    (st_wreq),
    .st_waddr_o   (st_waddr),
    .st_wdata_o   (st_wdata),
    .st_wdone_i   (st_wdone),
    .st_wrefuse_i (st_wrefuse)
  );

  // protected buffer
  mbx_store u_store (
    .clk          (clk),
    .reset_n      (reset_n),
    .st_wreq_i    (st_wreq),
    .st_waddr_i   (st_waddr),
    .st_wdata_i   (st_wdata),
    .st_wdone_o   (st_wdone),
    .st_wrefuse_o (st_wrefuse),
    .st_rreq_i    (st_rreq),
    .st_raddr_i   (st_raddr),
    .st_rdone_o   (st_rdone),
    .st_rhit_o    (st_rhit),
    .st_rdata_o   (st_rdata)
  );

  // consumer side
  mbx_read_port u_read_port (
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_cyc_i   (rd_cyc_i),
    .rd_stb_i   (rd_stb_i),
    .rd_adr_i   (rd_adr_i),
    .rd_dat_o   (rd_dat_o),
    .rd_ack_o   (rd_ack_o),
    .rd_err_o   (rd_err_o),
    .st_rreq_o  (st_rreq),
    .st_raddr_o (st_raddr),
    .st_rdone_i (st_rdone),
    .st_rhit_i  (st_rhit),
    .st_rdata_i (st_rdata)
  );

endmodule

// ==== tests/mbx_assertions.sv ====
`timescale 1ns/10ps

module mbx_assertions (
  input logic clk,
  input logic reset_n,
  input logic wr_cyc_i,
  input logic wr_stb_i,
  input logic wr_ack_o,
  input logic wr_err_o,
  input logic rd_cyc_i,
  input logic rd_stb_i,
  input logic rd_ack_o,
  input logic rd_err_o
);

  // ack and err never together
  a_wr_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(wr_ack_o && wr_err_o)) else $error("write port raised ack and err together");

  a_rd_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(rd_ack_o && rd_err_o)) else $error("read port raised ack and err together");

  // one clock per response
  a_wr_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    (wr_ack_o || wr_err_o) |=> !(wr_ack_o || wr_err_o))
    else $error("write response held for more than one cycle");

  a_rd_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    (rd_ack_o || rd_err_o) |=> !(rd_ack_o || rd_err_o))
    else $error("read response held for more than one cycle");

  // response only inside a strobed cycle
  a_wr_stb: assert property (@(posedge clk) disable iff (!reset_n)
    (wr_ack_o || wr_err_o) |-> (wr_cyc_i && wr_stb_i))
    else $error("write response without strobe");

  a_rd_stb: assert property (@(posedge clk) disable iff (!reset_n)
    (rd_ack_o || rd_err_o) |-> (rd_cyc_i && rd_stb_i))
    else $error("read response without strobe");

endmodule

bind mbx_top mbx_assertions u_assertions (
  .clk      (clk),
  .reset_n  (reset_n),
  .wr_cyc_i (wr_cyc_i),
  .wr_stb_i (wr_stb_i),
  .wr_ack_o (wr_ack_o),
  .wr_err_o (wr_err_o),
  .rd_cyc_i (rd_cyc_i),
  .rd_stb_i (rd_stb_i),
  .rd_ack_o (rd_ack_o),
  .rd_err_o (rd_err_o)
);

// ==== tests/mbx_tb.sv ====
`timescale 1ns/10ps
`include "mbx_defs.svh"

module mbx_tb;

  localparam int NUM_SLOTS = 1 << `MBX_IDX_BITS;
  // issue, store, respond
  localparam int OK_CYCLES = 3;
  // every refusal but the last one costs another issue and store cycle
  localparam int ERR_WR_CYCLES = OK_CYCLES + 2 * (`MBX_RETRY_LIMIT - 1);
  localparam int TIMEOUT = 40;
  // two tags so that random traffic both hits and misses
  localparam mbx_pkg::tag_t TAG_A = 6'h15;
  localparam mbx_pkg::tag_t TAG_B = 6'h2a;

  logic           clk;
  logic           reset_n;
  logic           wr_cyc_i;
  logic           wr_stb_i;
  mbx_pkg::addr_t wr_adr_i;
  mbx_pkg::data_t wr_dat_i;
  logic           wr_ack_o;
  logic           wr_err_o;
  logic           rd_cyc_i;
  logic           rd_stb_i;
  mbx_pkg::addr_t rd_adr_i;
  mbx_pkg::data_t rd_dat_o;
  logic           rd_ack_o;
  logic           rd_err_o;

  int resp_errs;
  int data_errs;
  int cycle_errs;
  int timeout_errs;
  bit reported;
  logic [31:0] lfsr_q;

  // reference copy of the store state
  mbx_pkg::data_t m_data  [NUM_SLOTS];
  mbx_pkg::tag_t  m_tag   [NUM_SLOTS];
  bit             m_valid [NUM_SLOTS];
  bit             m_read  [NUM_SLOTS];

  mbx_top UUT (
    .clk      (clk),
    .reset_n  (reset_n),
    .wr_cyc_i (wr_cyc_i),
    .wr_stb_i (wr_stb_i),
    .wr_adr_i (wr_adr_i),
    .wr_dat_i (wr_dat_i),
    .wr_ack_o (wr_ack_o),
    .wr_err_o (wr_err_o),
    .rd_cyc_i (rd_cyc_i),
    .rd_stb_i (rd_stb_i),
    .rd_adr_i (rd_adr_i),
    .rd_dat_o (rd_dat_o),
    .rd_ack_o (rd_ack_o),
    .rd_err_o (rd_err_o)
  );

  always #10 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // empty and writable, as after reset
  function automatic void clear_model();
    for (int i = 0; i < NUM_SLOTS; i++) begin
      m_data[i]  = '0;
      m_tag[i]   = '0;
      m_valid[i] = 1'b0;
      m_read[i]  = 1'b1;
    end
  endfunction

  // write taken only over a word that was read
  function automatic mbx_pkg::mbx_resp_e predict_write(input mbx_pkg::addr_t adr,
                                                       input mbx_pkg::data_t dat);
    mbx_pkg::idx_t idx;
    idx = adr[`MBX_IDX_BITS-1:0];
    if (!m_read[idx]) begin
      return mbx_pkg::RESP_ERR;
    end
    m_data[idx]  = dat;
    m_tag[idx]   = adr[`MBX_ADDR_WIDTH-1:`MBX_IDX_BITS];
    m_valid[idx] = 1'b1;
    m_read[idx]  = 1'b0;
    return mbx_pkg::RESP_ACK;
  endfunction

  // hit on valid slot with same tag, hit frees the slot
  function automatic mbx_pkg::mbx_resp_e predict_read(input mbx_pkg::addr_t adr,
                                                      output mbx_pkg::data_t dat);
    mbx_pkg::idx_t idx;
    idx = adr[`MBX_IDX_BITS-1:0];
    dat = m_data[idx];
    if (m_valid[idx] && (m_tag[idx] == adr[`MBX_ADDR_WIDTH-1:`MBX_IDX_BITS])) begin
      m_read[idx] = 1'b1;
      return mbx_pkg::RESP_ACK;
    end
    return mbx_pkg::RESP_ERR;
  endfunction

  task automatic check_resp(input string name, input mbx_pkg::mbx_resp_e got,
                            input mbx_pkg::mbx_resp_e exp);
    if (got !== exp) begin
      $display("** Error %s: got %0h, expected %0h", name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_data(input string name, input mbx_pkg::data_t got,
                            input mbx_pkg::data_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %0h, expected %0h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error %s: got %0h, expected %0h", name, got, exp);
      cycle_errs++;
    end
  endtask

  // one write bus cycle, latency counted in clocks from the strobe
  task automatic do_write(input mbx_pkg::addr_t adr, input mbx_pkg::data_t dat,
                          output mbx_pkg::mbx_resp_e resp, output int cycles, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    @(negedge clk);
    wr_cyc_i = 1'b1;
    wr_stb_i = 1'b1;
    wr_adr_i = adr;
    wr_dat_i = dat;
    while (!ok && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if (wr_ack_o || wr_err_o) begin
        ok = 1'b1;
      end
    end
    resp   = wr_ack_o ? mbx_pkg::RESP_ACK : mbx_pkg::RESP_ERR;
    cycles = n;
    if (!ok) begin
      $display("write to address %0h got no ack or err within %0d cycles", adr, TIMEOUT);
      timeout_errs++;
    end
    // strobe held through the response clock
    @(negedge clk);
    wr_cyc_i = 1'b0;
    wr_stb_i = 1'b0;
  endtask

  task automatic do_read(input mbx_pkg::addr_t adr, output mbx_pkg::mbx_resp_e resp,
                         output mbx_pkg::data_t dat, output int cycles, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    @(negedge clk);
    rd_cyc_i = 1'b1;
    rd_stb_i = 1'b1;
    rd_adr_i = adr;
    while (!ok && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if (rd_ack_o || rd_err_o) begin
        ok = 1'b1;
      end
    end
    resp   = rd_ack_o ? mbx_pkg::RESP_ACK : mbx_pkg::RESP_ERR;
    dat    = rd_dat_o;
    cycles = n;
    if (!ok) begin
      $display("read of address %0h got no ack or err within %0d cycles", adr, TIMEOUT);
      timeout_errs++;
    end
    @(negedge clk);
    rd_cyc_i = 1'b0;
    rd_stb_i = 1'b0;
  endtask

  task automatic write_and_check(input mbx_pkg::addr_t adr, input mbx_pkg::data_t dat);
    mbx_pkg::mbx_resp_e exp;
    mbx_pkg::mbx_resp_e got;
    int                 cyc;
    bit                 ok;
    exp = predict_write(adr, dat);
    do_write(adr, dat, got, cyc, ok);
    if (ok) begin
      check_resp("wr_ack_o/wr_err_o", got, exp);
      check_cycles("write latency", cyc,
                   (exp == mbx_pkg::RESP_ACK) ? OK_CYCLES : ERR_WR_CYCLES);
    end
  endtask

  task automatic read_and_check(input mbx_pkg::addr_t adr);
    mbx_pkg::mbx_resp_e exp;
    mbx_pkg::mbx_resp_e got;
    mbx_pkg::data_t     exp_dat;
    mbx_pkg::data_t     dat;
    int                 cyc;
    bit                 ok;
    exp = predict_read(adr, exp_dat);
    do_read(adr, got, dat, cyc, ok);
    if (ok) begin
      check_resp("rd_ack_o/rd_err_o", got, exp);
      check_cycles("read latency", cyc, OK_CYCLES);
      // data only defined with ack
      if (exp == mbx_pkg::RESP_ACK && got == mbx_pkg::RESP_ACK) begin
        check_data("rd_dat_o", dat, exp_dat);
      end
    end
  endtask

  // every read misses, first writes all taken
  task automatic empty_after_reset();
    logic [31:0] r;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      read_and_check({TAG_A, mbx_pkg::idx_t'(i)});
    end
    for (int i = 0; i < NUM_SLOTS; i++) begin
      r = next_bits(16);
      write_and_check({TAG_A, mbx_pkg::idx_t'(i)}, r[15:0]);
    end
  endtask

  task automatic tag_match_read();
    read_and_check({TAG_A, mbx_pkg::idx_t'(0)});
    // same index, other tag
    read_and_check({TAG_B, mbx_pkg::idx_t'(1)});
    // slot 1 still protected after the miss
    write_and_check({TAG_B, mbx_pkg::idx_t'(1)}, 16'hbeef);
    read_and_check({TAG_A, mbx_pkg::idx_t'(1)});
  endtask

  task automatic overwrite_protection();
    // unread word, runs out of retries
    write_and_check({TAG_A, mbx_pkg::idx_t'(2)}, 16'h1234);
    read_and_check({TAG_A, mbx_pkg::idx_t'(2)});
    write_and_check({TAG_B, mbx_pkg::idx_t'(2)}, 16'h5678);
    read_and_check({TAG_B, mbx_pkg::idx_t'(2)});
  endtask

  task automatic repeated_reads();
    repeat (3) begin
      read_and_check({TAG_B, mbx_pkg::idx_t'(2)});
    end
    // slot 0 was freed earlier
    write_and_check({TAG_A, mbx_pkg::idx_t'(0)}, 16'hcafe);
    read_and_check({TAG_B, mbx_pkg::idx_t'(2)});
  endtask

  task automatic random_traffic();
    logic [31:0]    op;
    logic [31:0]    sel;
    logic [31:0]    idx;
    logic [31:0]    dat;
    mbx_pkg::addr_t adr;
    repeat (200) begin
      op  = next_bits(1);
      sel = next_bits(1);
      idx = next_bits(`MBX_IDX_BITS);
      adr = {sel[0] ? TAG_A : TAG_B, idx[`MBX_IDX_BITS-1:0]};
      if (op[0]) begin
        dat = next_bits(16);
        write_and_check(adr, dat[15:0]);
      end else begin
        read_and_check(adr);
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    wr_cyc_i     = 1'b0;
    wr_stb_i     = 1'b0;
    wr_adr_i     = '0;
    wr_dat_i     = '0;
    rd_cyc_i     = 1'b0;
    rd_stb_i     = 1'b0;
    rd_adr_i     = '0;
    resp_errs    = 0;
    data_errs    = 0;
    cycle_errs   = 0;
    timeout_errs = 0;
    reported     = 1'b0;
    lfsr_q       = 32'h7022;
    clear_model();
    repeat (3) @(negedge clk);
    reset_n = 1'b1;

    empty_after_reset();
    tag_match_read();
    overwrite_protection();
    repeated_reads();
    random_traffic();

    $display("errors: resp %0d, data %0d, latency %0d, timeout %0d",
             resp_errs, data_errs, cycle_errs, timeout_errs);
    if (resp_errs + data_errs + cycle_errs + timeout_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    reported = 1'b1;
    $finish;
  end

  // run stopped before the closing report, e.g. by an assertion
  final begin
    if (!reported) begin
      $display("Testbench failed");
    end
  end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/mbx_pkg.sv
rtl/mbx_write_port.sv
rtl/mbx_store.sv
rtl/mbx_read_port.sv
rtl/mbx_top.sv
tests/mbx_assertions.sv
tests/mbx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mailbox testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module mbx_tb \
  --Mdir obj_dir \
  -o mbx_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/mbx_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -Fqx "Testbench passed"; then
  exit 0
fi
exit 1
